// ==== hdl/pm_pkg.sv ====
package pm_pkg;

	// instruction word width
	localparam int IR_W = 16;

	// instruction field positions
	localparam int OP_HI = 15;
	localparam int OP_LO = 10;
	localparam int D_BIT = 9;
	localparam int A_HI = 8;
	localparam int A_LO = 6;
	localparam int B_HI = 5;
	localparam int B_LO = 3;
	localparam int C_HI = 2;
	localparam int C_LO = 0;

	// opcodes the control unit tells apart
	localparam logic [5:0] OP_LW = 6'o20;
	localparam logic [5:0] OP_SHC = 6'o36;
	localparam logic [5:0] OP_HLT = 6'o73;

	// main loop instruction states
	typedef enum logic [2:0] {
		P1 = 3'd0,
		P2 = 3'd1,
		P3 = 3'd2,
		P4 = 3'd3,
		P5 = 3'd4,
		PI = 3'd5
	} pm_state_t;

	// field extraction
	function automatic logic [OP_HI-OP_LO:0] ir_op(input logic [IR_W-1:0] ir);
		return ir[OP_HI:OP_LO];
	endfunction

	function automatic logic ir_d(input logic [IR_W-1:0] ir);
		return ir[D_BIT];
	endfunction

	function automatic logic [A_HI-A_LO:0] ir_a(input logic [IR_W-1:0] ir);
		return ir[A_HI:A_LO];
	endfunction

	function automatic logic [B_HI-B_LO:0] ir_b(input logic [IR_W-1:0] ir);
		return ir[B_HI:B_LO];
	endfunction

	function automatic logic [C_HI-C_LO:0] ir_c(input logic [IR_W-1:0] ir);
		return ir[C_HI:C_LO];
	endfunction

endpackage

// ==== hdl/cycle_timer.sv ====
module cycle_timer #(
	parameter int CYCLE_LEN = 4
) (
	input  logic clk,
	input  logic rst,
	input  logic start_req,
	input  logic stop_req,
	input  logic irq,
	input  logic exec_halt,
	output logic run,
	output logic waiting,
	output logic strob1,
	output logic strob2,
	output logic cycle_end
);

	localparam int PH_W = $clog2(CYCLE_LEN);
	localparam logic [PH_W-1:0] PH_STROB1 = PH_W'(1);
	localparam logic [PH_W-1:0] PH_STROB2 = PH_W'(2);
	localparam logic [PH_W-1:0] PH_LAST = PH_W'(CYCLE_LEN - 1);

	logic start_q;
	logic wait_q;
	logic [PH_W-1:0] phase;
	logic busy;

	// START flip-flop
	// stop wins if both requests arrive together
	always_ff @(posedge clk) begin
		if (rst) begin
			start_q <= 1'b0;
		end else if (stop_req) begin
			start_q <= 1'b0;
		end else if (start_req) begin
			start_q <= 1'b1;
		end
	end

	// WAIT flip-flop
	// set by halt at the end of P5, released by any interrupt
	always_ff @(posedge clk) begin
		if (rst) begin
			wait_q <= 1'b0;
		end else if (exec_halt) begin
			wait_q <= 1'b1;
		end else if (irq) begin
			wait_q <= 1'b0;
		end
	end

	assign run = start_q & ~wait_q;
	assign waiting = wait_q;

	// a started cycle always runs to its end
	assign busy = (phase != '0);

	// phase counter in place of the cycle start/end univibrators
	always_ff @(posedge clk) begin
		if (rst) begin
			phase <= '0;
		end else if (run || busy) begin
			if (phase == PH_LAST) begin
				phase <= '0;
			end else begin
				phase <= phase + 1'b1;
			end
		end
	end

	// strobes decoded straight from the phase register
	assign strob1 = (phase == PH_STROB1);
	assign strob2 = (phase == PH_STROB2);
	assign cycle_end = (phase == PH_LAST);

endmodule

// ==== hdl/state_seq.sv ====
module state_seq
	import pm_pkg::*;
(
	input  logic            clk,
	input  logic            rst,
	input  logic            strob2,
	input  logic            cycle_end,
	input  logic            irq,
	input  logic [IR_W-1:0] ir,
	output pm_state_t       state,
	output logic [IR_W-1:0] ir_q,
	output logic            exec_halt
);

	logic [5:0] op;
	logic fld_d;
	logic [2:0] fld_b;
	logic [2:0] fld_c;
	logic is_shc;
	logic is_hlt;

	// step counter LK
	logic [2:0] lk;
	logic lk_zero;

	pm_state_t next_state;
	logic enter_p5;

	// after premodification: B-modification only when b is set
	function automatic pm_state_t after_premod(input logic [2:0] b);
		if (b != 3'd0) begin
			return P3;
		end
		return P5;
	endfunction

	// after the argument: premodification first if d is set
	function automatic pm_state_t after_arg(input logic d, input logic [2:0] b);
		if (d) begin
			return P4;
		end
		return after_premod(b);
	endfunction

	// instruction register, loaded during fetch
	always_ff @(posedge clk) begin
		if (strob2 && state == P1) begin
			ir_q <= ir;
		end
	end

	assign op = ir_op(ir_q);
	assign fld_d = ir_d(ir_q);
	assign fld_b = ir_b(ir_q);
	assign fld_c = ir_c(ir_q);

	assign is_shc = (op == OP_SHC);
	assign is_hlt = (op == OP_HLT);
	assign lk_zero = (lk == 3'd0);

	always_comb begin
		next_state = P1;
		case (state)
			P1: begin
				if (is_shc) begin
					// shift count sits in c, no argument word
					next_state = P5;
				end else if (fld_c == 3'd0) begin
					next_state = P2;
				end else begin
					next_state = after_arg(fld_d, fld_b);
				end
			end
			P2: begin
				next_state = after_arg(fld_d, fld_b);
			end
			P4: begin
				next_state = after_premod(fld_b);
			end
			P3: begin
				next_state = P5;
			end
			P5: begin
				if (!lk_zero) begin
					// shift steps left, repeat execute
					next_state = P5;
				end else if (is_hlt || irq) begin
					// halt always resumes through interrupt accept
					next_state = PI;
				end else begin
					next_state = P1;
				end
			end
			PI: begin
				next_state = P1;
			end
			default: begin
				next_state = P1;
			end
		endcase
	end

	// state moves on the edge that closes cycle_end
	always_ff @(posedge clk) begin
		if (rst) begin
			state <= P1;
		end else if (cycle_end) begin
			state <= next_state;
		end
	end

	assign enter_p5 = (state != P5) && (next_state == P5);

	// LK loaded on entry to P5, counted down once per P5 cycle
	always_ff @(posedge clk) begin
		if (rst) begin
			lk <= 3'd0;
		end else if (cycle_end) begin
			if (enter_p5) begin
				lk <= is_shc ? fld_c : 3'd0;
			end else if (state == P5 && !lk_zero) begin
				lk <= lk - 3'd1;
			end
		end
	end

	// WAIT sets on the edge that closes the halt's P5 cycle
	assign exec_halt = cycle_end && (state == P5) && is_hlt && lk_zero;

endmodule

// ==== hdl/uop_decode.sv ====
module uop_decode
	import pm_pkg::*;
(
	input  logic            clk,
	input  logic            rst,
	input  logic            strob2,
	input  pm_state_t       state,
	input  logic [IR_W-1:0] ir_q,
	output logic            w_ir,
	output logic            w_ic,
	output logic            w_ar,
	output logic            w_ac,
	output logic            int_ack,
	output logic [2:0]      reg_sel
);

	logic [5:0] op;
	logic [2:0] fld_a;
	logic [2:0] fld_b;
	logic is_lw;

	assign op = ir_op(ir_q);
	assign fld_a = ir_a(ir_q);
	assign fld_b = ir_b(ir_q);

	// load never repeats execute, its only P5 cycle is the last one
	assign is_lw = (op == OP_LW);

	// W bus strobes, one clock each, right after strob2
	always_ff @(posedge clk) begin
		if (rst) begin
			w_ir <= 1'b0;
			w_ic <= 1'b0;
			w_ar <= 1'b0;
			w_ac <= 1'b0;
			int_ack <= 1'b0;
		end else begin
			w_ir <= strob2 && (state == P1);
			w_ic <= strob2 && (state == P1 || state == P2);
			w_ar <= strob2 && (state == P2 || state == P3 || state == P4);
			w_ac <= strob2 && (state == P5) && is_lw;
			int_ack <= strob2 && (state == PI);
		end
	end

	// general register select, follows state one clock behind
	always_ff @(posedge clk) begin
		if (rst) begin
			reg_sel <= 3'd0;
		end else begin
			case (state)
				P5: reg_sel <= fld_a;
				P3: reg_sel <= fld_b;
				default: reg_sel <= 3'd0;
			endcase
		end
	end

endmodule

// ==== hdl/pm_top.sv ====
module pm_top
	import pm_pkg::*;
#(
	parameter int CYCLE_LEN = 4
) (
	input  logic            clk,
	input  logic            rst,
	input  logic            start_req,
	input  logic            stop_req,
	input  logic            irq,
	input  logic [IR_W-1:0] ir,
	output logic            run,
	output logic            waiting,
	output pm_state_t       state,
	output logic            strob1,
	output logic            strob2,
	output logic            cycle_end,
	output logic            w_ir,
	output logic            w_ic,
	output logic            w_ar,
	output logic            w_ac,
	output logic            int_ack,
	output logic [2:0]      reg_sel
);

	logic exec_halt;
	logic [IR_W-1:0] ir_q;

	// start/stop, WAIT and cycle phases
	cycle_timer #(
		.CYCLE_LEN(CYCLE_LEN)
	) u_timer (
		.clk(clk),
		.rst(rst),
		.start_req(start_req),
		.stop_req(stop_req),
		.irq(irq),
		.exec_halt(exec_halt),
		.run(run),
		.waiting(waiting),
		.strob1(strob1),
		.strob2(strob2),
		.cycle_end(cycle_end)
	);

	// P states and LK
	state_seq u_seq (
		.clk(clk),
		.rst(rst),
		.strob2(strob2),
		.cycle_end(cycle_end),
		.irq(irq),
		.ir(ir),
		.state(state),
		.ir_q(ir_q),
		.exec_halt(exec_halt)
	);

	// microoperations
	uop_decode u_dec (
		.clk(clk),
		.rst(rst),
		.strob2(strob2),
		.state(state),
		.ir_q(ir_q),
		.w_ir(w_ir),
		.w_ic(w_ic),
		.w_ar(w_ar),
		.w_ac(w_ac),
		.int_ack(int_ack),
		.reg_sel(reg_sel)
	);

endmodule

// ==== sim/pm_props.sv ====
module pm_props (
	input logic       clk,
	input logic       rst,
	input logic       strob2,
	input logic       w_ir,
	input logic       w_ic,
	input logic       w_ar,
	input logic       w_ac,
	input logic       int_ack,
	input logic [2:0] reg_sel
);

	// fetch, address and interrupt accept never share a clock
	assert property (@(posedge clk) disable iff (rst) $onehot0({w_ir, w_ar, int_ack}))
		else $error("w_ir, w_ar and int_ack high together");

	// every microoperation comes from the strob2 one clock earlier
	assert property (@(posedge clk) disable iff (rst)
		(w_ir || w_ic || w_ar || w_ac || int_ack) |-> $past(strob2))
		else $error("microoperation without strob2 one clock before");

	// reset clears all decoder outputs
	assert property (@(posedge clk)
		rst |=> !(w_ir || w_ic || w_ar || w_ac || int_ack) && reg_sel == 3'd0)
		else $error("decoder output high during reset");

endmodule

bind uop_decode pm_props u_props (
	.clk(clk),
	.rst(rst),
	.strob2(strob2),
	.w_ir(w_ir),
	.w_ic(w_ic),
	.w_ar(w_ar),
	.w_ac(w_ac),
	.int_ack(int_ack),
	.reg_sel(reg_sel)
);

// ==== sim/pm_tb.sv ====
module pm_tb
	import pm_pkg::*;
();

	localparam int CYCLE_LEN = 4;
	localparam int PERIOD = 40;
	localparam int N_INSTR = 400;
	// shift with c of 7 is nine cycles, then PI, plus a short halt wait
	localparam int WORST_CYC = 12;
	localparam longint TIMEOUT = longint'(N_INSTR) * WORST_CYC * CYCLE_LEN * PERIOD
		+ 500 * PERIOD;

	logic clk;
	logic rst;
	logic start_req;
	logic stop_req;
	logic irq;
	logic [IR_W-1:0] ir;
	logic run;
	logic waiting;
	pm_state_t state;
	logic strob1;
	logic strob2;
	logic cycle_end;
	logic w_ir;
	logic w_ic;
	logic w_ar;
	logic w_ac;
	logic int_ack;
	logic [2:0] reg_sel;

	integer seed = 32'h271c;
	int instr_count;
	int halt_count;
	int ack_count;
	logic restarted;

	// reference model, values after the last rising edge
	logic m_start;
	logic m_wait;
	int m_phase;
	pm_state_t m_state;
	logic [IR_W-1:0] m_ir_q;
	logic [2:0] m_lk;
	logic e_w_ir;
	logic e_w_ic;
	logic e_w_ar;
	logic e_w_ac;
	logic e_int_ack;
	logic [2:0] e_reg_sel;

	pm_top #(
		.CYCLE_LEN(CYCLE_LEN)
	) DUT (
		.clk(clk),
		.rst(rst),
		.start_req(start_req),
		.stop_req(stop_req),
		.irq(irq),
		.ir(ir),
		.run(run),
		.waiting(waiting),
		.state(state),
		.strob1(strob1),
		.strob2(strob2),
		.cycle_end(cycle_end),
		.w_ir(w_ir),
		.w_ic(w_ic),
		.w_ar(w_ar),
		.w_ac(w_ac),
		.int_ack(int_ack),
		.reg_sel(reg_sel)
	);

	initial begin
		clk = 1'b0;
		forever #(PERIOD / 2) clk = ~clk;
	end

	task automatic value_mismatch(input string name, input logic [7:0] exp,
			input logic [7:0] got);
		$display("** Error at time %0t: %s expected %0h, got %0h", $time, name, exp, got);
		$display("Simulation failed");
		$fatal(1, "stopped at first mismatch");
	endtask

	task automatic plain_failure(input string what);
		$display("%s", what);
		$display("Simulation failed");
		$fatal(1, "stopped");
	endtask

	initial begin
		#(TIMEOUT);
		plain_failure("watchdog expired before the instruction stream finished");
	end

	// argument and modification path after fetch or argument
	function automatic pm_state_t operand_path(input logic d, input logic [2:0] b);
		if (d) begin
			return P4;
		end else if (b != 3'd0) begin
			return P3;
		end
		return P5;
	endfunction

	// weighted toward halt, shift and load
	function automatic logic [IR_W-1:0] random_word();
		logic [IR_W-1:0] w;
		int pick;
		w = IR_W'($random(seed));
		pick = $random(seed) & 7;
		case (pick)
			0: w[OP_HI:OP_LO] = OP_HLT;
			1, 2: w[OP_HI:OP_LO] = OP_SHC;
			3, 4: w[OP_HI:OP_LO] = OP_LW;
			default: begin
			end
		endcase
		return w;
	endfunction

	// model of one rising edge with the inputs now driven
	task automatic predict_next();
		logic s2;
		logic ce;
		logic halt;
		logic run_now;
		logic [5:0] op;
		logic [2:0] b;
		logic [2:0] c;
		pm_state_t nxt;

		s2 = (m_phase == 2);
		ce = (m_phase == CYCLE_LEN - 1);
		op = m_ir_q[OP_HI:OP_LO];
		b = m_ir_q[B_HI:B_LO];
		c = m_ir_q[C_HI:C_LO];
		run_now = m_start && !m_wait;
		halt = ce && m_state == P5 && op == OP_HLT && m_lk == 3'd0;

		case (m_state)
			P1: begin
				if (op == OP_SHC) begin
					nxt = P5;
				end else if (c == 3'd0) begin
					nxt = P2;
				end else begin
					nxt = operand_path(m_ir_q[D_BIT], b);
				end
			end
			P2: nxt = operand_path(m_ir_q[D_BIT], b);
			P4: nxt = (b != 3'd0) ? P3 : P5;
			P3: nxt = P5;
			P5: begin
				if (m_lk != 3'd0) begin
					nxt = P5;
				end else if (op == OP_HLT || irq) begin
					nxt = PI;
				end else begin
					nxt = P1;
				end
			end
			default: nxt = P1;
		endcase

		e_w_ir = s2 && m_state == P1;
		e_w_ic = s2 && (m_state == P1 || m_state == P2);
		e_w_ar = s2 && (m_state == P2 || m_state == P3 || m_state == P4);
		e_w_ac = s2 && m_state == P5 && op == OP_LW && m_lk == 3'd0;
		e_int_ack = s2 && m_state == PI;
		case (m_state)
			P5: e_reg_sel = m_ir_q[A_HI:A_LO];
			P3: e_reg_sel = b;
			default: e_reg_sel = 3'd0;
		endcase
		if (e_int_ack) begin
			ack_count++;
		end
		if (halt) begin
			halt_count++;
		end

		if (s2 && m_state == P1) begin
			m_ir_q = ir;
		end
		if (ce) begin
			if (m_state != P5 && nxt == P5) begin
				m_lk = (op == OP_SHC) ? c : 3'd0;
			end else if (m_state == P5 && m_lk != 3'd0) begin
				m_lk = m_lk - 3'd1;
			end
			m_state = nxt;
		end
		if (run_now || m_phase != 0) begin
			m_phase = (m_phase == CYCLE_LEN - 1) ? 0 : m_phase + 1;
		end
		if (halt) begin
			m_wait = 1'b1;
		end else if (irq) begin
			m_wait = 1'b0;
		end
		if (stop_req) begin
			m_start = 1'b0;
		end else if (start_req) begin
			m_start = 1'b1;
		end
	endtask

	task automatic compare_outputs();
		logic e_run;
		e_run = m_start && !m_wait;
		assert (run === e_run) else value_mismatch("run", 8'(e_run), 8'(run));
		assert (waiting === m_wait) else value_mismatch("waiting", 8'(m_wait), 8'(waiting));
		assert (state === m_state) else value_mismatch("state", 8'(m_state), 8'(state));
		assert (strob1 === (m_phase == 1))
			else value_mismatch("strob1", 8'(m_phase == 1), 8'(strob1));
		assert (strob2 === (m_phase == 2))
			else value_mismatch("strob2", 8'(m_phase == 2), 8'(strob2));
		assert (cycle_end === (m_phase == CYCLE_LEN - 1))
			else value_mismatch("cycle_end", 8'(m_phase == CYCLE_LEN - 1), 8'(cycle_end));
		assert (w_ir === e_w_ir) else value_mismatch("w_ir", 8'(e_w_ir), 8'(w_ir));
		assert (w_ic === e_w_ic) else value_mismatch("w_ic", 8'(e_w_ic), 8'(w_ic));
		assert (w_ar === e_w_ar) else value_mismatch("w_ar", 8'(e_w_ar), 8'(w_ar));
		assert (w_ac === e_w_ac) else value_mismatch("w_ac", 8'(e_w_ac), 8'(w_ac));
		assert (int_ack === e_int_ack)
			else value_mismatch("int_ack", 8'(e_int_ack), 8'(int_ack));
		assert (reg_sel === e_reg_sel)
			else value_mismatch("reg_sel", 8'(e_reg_sel), 8'(reg_sel));
	endtask

	task automatic step_clock();
		predict_next();
		@(negedge clk);
		compare_outputs();
	endtask

	task automatic drive_inputs();
		// irq as a level, held longer once raised, more eager while halted
		if (irq) begin
			irq = ($random(seed) & 3) != 0;
		end else if (m_wait) begin
			irq = ($random(seed) & 3) == 0;
		end else begin
			irq = ($random(seed) & 31) == 0;
		end
		// new word at strob1 of fetch, stable through strob2
		if (m_state == P1 && m_phase == 1) begin
			ir = random_word();
			instr_count++;
		end
	endtask

	task automatic start_pulse();
		start_req = 1'b1;
		step_clock();
		start_req = 1'b0;
	endtask

	// stop at phase 1 outside fetch, one more cycle_end expected
	task automatic stop_mid_cycle();
		int ends;
		ends = 0;
		while (m_phase != 1 || m_state == P1) begin
			irq = m_wait;
			step_clock();
		end
		irq = 1'b0;
		stop_req = 1'b1;
		step_clock();
		stop_req = 1'b0;
		if (cycle_end) begin
			ends++;
		end
		repeat (3 * CYCLE_LEN) begin
			step_clock();
			if (cycle_end) begin
				ends++;
			end
		end
		assert (ends == 1) else value_mismatch("cycle_end count after stop", 8'd1, 8'(ends));
		assert (run === 1'b0) else value_mismatch("run after stop", 8'd0, 8'(run));
	endtask

	initial begin
		rst = 1'b1;
		start_req = 1'b0;
		stop_req = 1'b0;
		irq = 1'b0;
		ir = '0;
		instr_count = 0;
		halt_count = 0;
		ack_count = 0;
		restarted = 1'b0;
		repeat (8) @(negedge clk);
		rst = 1'b0;

		m_start = 1'b0;
		m_wait = 1'b0;
		m_phase = 0;
		m_state = P1;
		m_ir_q = '0;
		m_lk = 3'd0;
		e_w_ir = 1'b0;
		e_w_ic = 1'b0;
		e_w_ar = 1'b0;
		e_w_ac = 1'b0;
		e_int_ack = 1'b0;
		e_reg_sel = 3'd0;
		compare_outputs();

		// idle, nothing may move before start_req
		repeat (5 * CYCLE_LEN) step_clock();
		start_pulse();

		while (instr_count < N_INSTR) begin
			if (instr_count == N_INSTR / 2 && !restarted) begin
				stop_mid_cycle();
				start_pulse();
				restarted = 1'b1;
			end
			drive_inputs();
			step_clock();
		end
		stop_mid_cycle();
		repeat (5 * CYCLE_LEN) step_clock();

		assert (halt_count > 0) else plain_failure("no halt instruction reached execute");
		assert (ack_count > 0) else plain_failure("no interrupt accept cycle was seen");
		$display("Simulation completed successfully");
		$finish;
	end

endmodule

// ==== flist.f ====
hdl/pm_pkg.sv
hdl/cycle_timer.sv
hdl/state_seq.sv
hdl/uop_decode.sv
hdl/pm_top.sv
sim/pm_props.sv
sim/pm_tb.sv

// ==== Makefile ====
SIM := obj_dir/Vpm_tb

.PHONY: all run clean

all: run

$(SIM): flist.f $(shell cat flist.f)
	verilator --binary --assert --top-module pm_tb -f flist.f

run: $(SIM)
	-./$(SIM) > sim.log 2>&1
	cat sim.log
	grep -q "Simulation completed successfully" sim.log

clean:
	rm -rf obj_dir sim.log
